// File: audio_mixer.sv
`timescale 1ns/1ps
`include "zx_io_consts.svh"

module audio_mixer (
  input  logic                    clk_28mhz,
  input  logic                    rst,
  input  zx_audio_pkg::audio_in_t aud,
  output zx_audio_pkg::sample_t   audio_l,
  output zx_audio_pkg::sample_t   audio_r,
  output logic                    beep
);

  import zx_audio_pkg::*;

  // all three sources at full scale
  localparam sample_t MIX_MAX = `ZX_BEEP_LVL + `ZX_TAPE_LVL +
                                (sample_t'(8'hFF) << `ZX_COVOX_SHIFT);

  sample_t beep_term;
  sample_t tape_term;
  sample_t covox_term;
  sample_t mix_sum;
  sample_t mix_q;

  assign beep_term  = aud.speaker ? `ZX_BEEP_LVL : '0;
  assign tape_term  = aud.tape_in ? `ZX_TAPE_LVL : '0;
  assign covox_term = sample_t'(aud.covox) << `ZX_COVOX_SHIFT;
  assign mix_sum    = beep_term + tape_term + covox_term;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      mix_q <= '0;
      beep  <= 1'b0;
    end else begin
      mix_q <= mix_sum;
      beep  <= aud.speaker;
    end
  end

  // mono mix on both channels
  assign audio_l = mix_q;
  assign audio_r = mix_q;

  // no wrap past full scale
  a_mix_range: assert property (@(posedge clk_28mhz) disable iff (rst)
    audio_l <= MIX_MAX);

endmodule

// File: int_ctrl.sv
`timescale 1ns/1ps
`include "zx_io_consts.svh"

module int_ctrl #(
  parameter int frame_clks = 560000
) (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  input  logic                 intack_stb,
  input  logic                 ext_int,
  input  zx_bus_pkg::int_src_t int_mask,
  output logic                 int_n,
  output logic [7:0]           vector,
  output logic                 vec_src_valid
);

  import zx_bus_pkg::*;

  localparam int FRAME_W = $clog2(frame_clks);
  localparam int LEN_W   = $clog2(`ZX_INT_LEN);

  logic [FRAME_W-1:0] frame_cnt;
  logic [LEN_W-1:0]   len_cnt;
  logic [2:0]         ext_sr;
  logic               frame_wrap;
  logic               line_rise;
  logic               len_done;
  int_src_t           pend;
  int_src_t           pend_en;
  int_src_t           pend_nxt;

  assign frame_wrap = frame_cnt == FRAME_W'(frame_clks - 1);
  assign line_rise  = ext_sr[1] & ~ext_sr[2];
  assign pend_en    = pend & int_mask;
  assign len_done   = (pend_en != '0) && (len_cnt == LEN_W'(`ZX_INT_LEN - 1));

  always_comb begin
    pend_nxt = pend;
    // acknowledge takes the highest priority source with frame first
    if (intack_stb) begin
      if (pend_en.frame) begin
        pend_nxt.frame = 1'b0;
      end else if (pend_en.line) begin
        pend_nxt.line = 1'b0;
      end
    end
    if (frame_wrap && int_mask.frame) begin
      pend_nxt.frame = 1'b1;
    end
    if (line_rise && int_mask.line) begin
      pend_nxt.line = 1'b1;
    end
    // timeout wins so int_n always goes high for a cycle
    if (len_done) begin
      pend_nxt = '0;
    end
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      frame_cnt <= '0;
      len_cnt   <= '0;
      ext_sr    <= '0;
      pend      <= '0;
    end else begin
      frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
      ext_sr    <= {ext_sr[1:0], ext_int};
      pend      <= pend_nxt;
      if (pend_en == '0 || len_done) begin
        len_cnt <= '0;
      end else begin
        len_cnt <= len_cnt + 1'b1;
      end
    end
  end

  assign int_n         = pend_en == '0;
  assign vec_src_valid = pend_en != '0;
  assign vector        = pend_en.frame ? `ZX_VEC_FRAME : `ZX_VEC_LINE;

  // int_n back high by the end of the allowed window
  a_int_len: assert property (@(posedge clk_28mhz) disable iff (rst)
    $fell(int_n) |-> ##(`ZX_INT_LEN) int_n);

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_zx_io -f verilog.f -o sim_zx_io

out=$(./obj_dir/sim_zx_io 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb_zx_io.sv
`timescale 1ns/1ps
`include "zx_io_consts.svh"

module tb_zx_io;

  localparam int FRAME_CLKS      = 2000;
  localparam int CLK_PERIOD      = 10;
  localparam int STB_CYCLES      = 6;
  // audio may settle up to 8 cycles after the write starts
  localparam int AUD_WAIT        = 8 - STB_CYCLES;
  localparam int WATCHDOG_CYCLES = 20 * FRAME_CLKS + 2000;
  localparam int CYC_WR          = 0;
  localparam int CYC_RD          = 1;
  localparam int CYC_ACK         = 2;

  logic        clk_28mhz;
  logic        rst;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [15:0] addr;
  logic [7:0]  data;
  logic        covox_en;
  logic        tape_in;
  logic [4:0]  kbd_data;
  logic        ext_int;
  logic [7:0]  cpu_di;
  logic        int_n;
  logic [2:0]  border;
  logic        tape_out;
  logic        beep;
  logic [15:0] audio_l;
  logic [15:0] audio_r;

  integer      seed = 32'h850071a2;
  logic [31:0] r;
  logic [7:0]  d;
  logic [7:0]  q;
  int          cyc = 0;
  int          t_fall;
  int          waited;
  int          fail_cnt = 0;
  int          sva_fail_cnt = 0;
  int          fails_before = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // expected register contents as tracked from the writes
  logic [7:0]  fe_sh;
  logic [7:0]  covox_sh;
  logic        tape_sh;

  zx_io_top #(
    .frame_clks (FRAME_CLKS)
  ) u_dut (.*);

  initial begin
    clk_28mhz = 1'b0;
    forever #(CLK_PERIOD / 2) clk_28mhz = ~clk_28mhz;
  end

  always @(posedge clk_28mhz) begin
    cyc <= cyc + 1;
  end

  // both channels carry the same mono mix
  a_stereo: assert property (@(posedge clk_28mhz) disable iff (rst) audio_r == audio_l)
    else begin
      $display("[FAIL] audio_r: got %0h, expected %0h", audio_r, audio_l);
      sva_fail_cnt++;
    end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [15:0] mix_model(input logic [7:0] fe, input logic tape,
                                            input logic [7:0] cv);
    logic [15:0] s;
    s = ({8'h00, cv} << `ZX_COVOX_SHIFT)
      + (fe[4] ? `ZX_BEEP_LVL : 16'h0000)
      + (tape ? `ZX_TAPE_LVL : 16'h0000);
    return s;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
      fail_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    int total;
    total = fail_cnt + sva_fail_cnt;
    tests_run++;
    if (total == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, total - fails_before);
    end
    fails_before = total;
  endtask

  // one Z80 I/O cycle
  // rdat holds cpu_di sampled mid-cycle
  task automatic bus_cycle(input int kind, input logic [15:0] a, input logic [7:0] dat,
                           output logic [7:0] rdat);
    @(posedge clk_28mhz);
    addr   <= a;
    data   <= dat;
    iorq_n <= 1'b0;
    wr_n   <= kind != CYC_WR;
    rd_n   <= kind != CYC_RD;
    m1_n   <= kind != CYC_ACK;
    repeat (3) @(posedge clk_28mhz);
    @(negedge clk_28mhz);
    rdat = cpu_di;
    repeat (STB_CYCLES - 3) @(posedge clk_28mhz);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    rd_n   <= 1'b1;
    m1_n   <= 1'b1;
  endtask

  task automatic wait_int_n(input logic level, input int limit, output int n);
    n = 0;
    @(negedge clk_28mhz);
    while (int_n !== level && n < limit) begin
      @(negedge clk_28mhz);
      n++;
    end
    assert (int_n === level) else begin
      $display("int_n did not reach %0b within %0d cycles", level, limit);
      fail_cnt++;
    end
  endtask

  task automatic watch_quiet(input int cycles);
    int lows;
    lows = 0;
    repeat (cycles) begin
      @(negedge clk_28mhz);
      if (int_n !== 1'b1) begin
        lows++;
      end
    end
    assert (lows == 0) else begin
      $display("int_n was low for %0d cycles with all interrupt sources masked", lows);
      fail_cnt++;
    end
  endtask

  task automatic check_outputs();
    logic [15:0] exp;
    int          n;
    exp = mix_model(fe_sh, tape_sh, covox_sh);
    n = 0;
    @(negedge clk_28mhz);
    while (audio_l !== exp && n < AUD_WAIT) begin
      @(negedge clk_28mhz);
      n++;
    end
    check_val("audio_l", 32'(audio_l), 32'(exp));
    check_val("audio_r", 32'(audio_r), 32'(exp));
    check_val("border", 32'(border), 32'(fe_sh[2:0]));
    check_val("tape_out", 32'(tape_out), 32'(fe_sh[3]));
    check_val("beep", 32'(beep), 32'(fe_sh[4]));
  endtask

  initial begin
    rst      = 1'b1;
    iorq_n   = 1'b1;
    rd_n     = 1'b1;
    wr_n     = 1'b1;
    m1_n     = 1'b1;
    addr     = 16'h0000;
    data     = 8'h00;
    covox_en = 1'b0;
    tape_in  = 1'b0;
    kbd_data = 5'h1F;
    ext_int  = 1'b0;
    fe_sh    = 8'h00;
    covox_sh = 8'h00;
    tape_sh  = 1'b0;

    repeat (4) @(posedge clk_28mhz);
    rst <= 1'b0;
    @(negedge clk_28mhz);
    check_val("int_n", 32'(int_n), 32'd1);
    check_val("beep", 32'(beep), 32'd0);
    check_val("tape_out", 32'(tape_out), 32'd0);
    check_val("border", 32'(border), 32'd0);
    check_val("audio_l", 32'(audio_l), 32'd0);
    check_val("audio_r", 32'(audio_r), 32'd0);
    end_test("reset_state");

    // any address with A0 low reaches the #FE register
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      @(posedge clk_28mhz);
      tape_in <= r[8];
      tape_sh = r[8];
      fe_sh = r[7:0];
      bus_cycle(CYC_WR, {r[31:24], 8'hFE}, fe_sh, q);
      check_outputs();
    end
    end_test("fe_port_write");

    // even passes enable the DAC and odd passes must leave it alone
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      @(posedge clk_28mhz);
      covox_en <= i[0] == 1'b0;
      d = (i[0] == 1'b0) ? r[15:8] : ~covox_sh;
      bus_cycle(CYC_WR, 16'h00FB, d, q);
      if (i[0] == 1'b0) begin
        covox_sh = d;
      end
      check_outputs();
    end
    end_test("covox_port");

    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      @(posedge clk_28mhz);
      tape_in  <= r[5];
      kbd_data <= r[4:0];
      bus_cycle(CYC_RD, {r[31:17], 1'b0}, 8'h00, q);
      check_val("cpu_di", 32'(q), 32'({1'b1, r[5], 1'b1, r[4:0]}));
      bus_cycle(CYC_RD, {r[31:17], 1'b1}, 8'h00, q);
      check_val("cpu_di", 32'(q), 32'hFF);
    end
    end_test("fe_port_read");

    // first frame acknowledged and second left to time out
    wait_int_n(1'b0, FRAME_CLKS + 64, waited);
    t_fall = cyc;
    bus_cycle(CYC_ACK, 16'h0000, 8'h00, q);
    check_val("cpu_di", 32'(q), 32'(`ZX_VEC_FRAME));
    wait_int_n(1'b1, 4, waited);
    wait_int_n(1'b0, FRAME_CLKS + 64, waited);
    check_val("int_n period", cyc - t_fall, FRAME_CLKS);
    wait_int_n(1'b1, `ZX_INT_LEN + 4, waited);
    // waited starts counting on the second low cycle
    assert (waited + 1 <= `ZX_INT_LEN) else begin
      $display("int_n stayed low for %0d cycles without an acknowledge", waited + 1);
      fail_cnt++;
    end
    end_test("frame_interrupt");

    bus_cycle(CYC_WR, {`ZX_PORT_INTMASK_HI, `ZX_PORT_INTMASK_LO}, 8'h02, q);
    @(posedge clk_28mhz);
    ext_int <= 1'b1;
    wait_int_n(1'b0, 8, waited);
    bus_cycle(CYC_ACK, 16'h0000, 8'h00, q);
    check_val("cpu_di", 32'(q), 32'(`ZX_VEC_LINE));
    wait_int_n(1'b1, 4, waited);
    @(posedge clk_28mhz);
    ext_int <= 1'b0;
    bus_cycle(CYC_WR, {`ZX_PORT_INTMASK_HI, `ZX_PORT_INTMASK_LO}, 8'h00, q);
    watch_quiet(FRAME_CLKS + 16);
    @(posedge clk_28mhz);
    ext_int <= 1'b1;
    watch_quiet(16);
    end_test("line_interrupt_mask");

    $display("%0d tests, %0d failed, %0d failed checks", tests_run, tests_failed,
             fail_cnt + sva_fail_cnt);
    if (fail_cnt + sva_fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
zx_bus_pkg.sv
zx_audio_pkg.sv
z80_bus_sync.sv
zx_ports.sv
int_ctrl.sv
audio_mixer.sv
zx_io_top.sv
tb_zx_io.sv

// File: z80_bus_sync.sv
`timescale 1ns/1ps

module z80_bus_sync (
  input  logic                  clk_28mhz,
  input  logic                  rst,
  input  logic                  iorq_n,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  m1_n,
  input  logic [15:0]           addr,
  input  logic [7:0]            data,
  output zx_bus_pkg::io_cycle_t io,
  output logic                  intack_stb
);

  // two sync stages plus one delay stage for edge detection
  logic [2:0]  wr_sr;
  logic [2:0]  ack_sr;
  logic [1:0]  rd_sr;
  logic        wr_start;
  logic        ack_start;
  logic        wr_stb_q;
  logic [15:0] addr_q;
  logic [7:0]  data_q;

  assign wr_start  = wr_sr[1] & ~wr_sr[2];
  assign ack_start = ack_sr[1] & ~ack_sr[2];

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_sr      <= '0;
      ack_sr     <= '0;
      rd_sr      <= '0;
      wr_stb_q   <= 1'b0;
      intack_stb <= 1'b0;
    end else begin
      wr_sr      <= {wr_sr[1:0], ~iorq_n & ~wr_n};
      ack_sr     <= {ack_sr[1:0], ~iorq_n & ~m1_n};
      rd_sr      <= {rd_sr[0], ~iorq_n & ~rd_n};
      wr_stb_q   <= wr_start;
      intack_stb <= ack_start;
    end
  end

  // address follows the bus, data only taken at the write start
  always_ff @(posedge clk_28mhz) begin
    addr_q <= addr;
    if (wr_start) begin
      data_q <= data;
    end
  end

  assign io = '{addr: addr_q, data: data_q, wr_stb: wr_stb_q, rd_act: rd_sr[1]};

  // one strobe per write cycle
  a_wr_stb_single: assert property (@(posedge clk_28mhz) disable iff (rst)
    io.wr_stb |=> !io.wr_stb);

endmodule

// File: zx_audio_pkg.sv
package zx_audio_pkg;

  // raw sound sources before mixing
  typedef struct packed {
    logic       speaker;
    logic       tape_in;
    logic [7:0] covox;
  } audio_in_t;

  // unsigned mixer output word
  typedef logic [15:0] sample_t;

endpackage

// File: zx_bus_pkg.sv
package zx_bus_pkg;

  // one synchronised port cycle as seen by the port block
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic        wr_stb;
    logic        rd_act;
  } io_cycle_t;

  // bit layout of the #FE byte
  typedef struct packed {
    logic [2:0] spare;
    logic       speaker;
    logic       tape_out;
    logic [2:0] border;
  } fe_fields_t;

  typedef union packed {
    logic [7:0] raw;
    fe_fields_t f;
  } fe_port_u;

  // interrupt sources in the same order as the mask port bits
  typedef struct packed {
    logic line;
    logic frame;
  } int_src_t;

endpackage

// File: zx_io_consts.svh
`ifndef ZX_IO_CONSTS_SVH
`define ZX_IO_CONSTS_SVH

// port decode
// only A0 of the #FE byte is decoded
`define ZX_PORT_FE_LO       8'hFE
`define ZX_PORT_COVOX       8'hFB
`define ZX_PORT_INTMASK_HI  8'h2A
`define ZX_PORT_INTMASK_LO  8'hAF

// IM2 vectors put on the bus during acknowledge
`define ZX_VEC_FRAME        8'hFF
`define ZX_VEC_LINE         8'hFD

// longest int_n low time in clk_28mhz cycles
`define ZX_INT_LEN          32

// mixer levels
`define ZX_BEEP_LVL         16'h2000
`define ZX_TAPE_LVL         16'h0800
`define ZX_COVOX_SHIFT      5

`endif

// File: zx_io_top.sv
`timescale 1ns/1ps

module zx_io_top #(
  parameter int frame_clks = 560000
) (
  input  logic                  clk_28mhz,
  input  logic                  rst,
  input  logic                  iorq_n,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  m1_n,
  input  logic [15:0]           addr,
  input  logic [7:0]            data,
  input  logic                  covox_en,
  input  logic                  tape_in,
  input  logic [4:0]            kbd_data,
  input  logic                  ext_int,
  output logic [7:0]            cpu_di,
  output logic                  int_n,
  output logic [2:0]            border,
  output logic                  tape_out,
  output logic                  beep,
  output zx_audio_pkg::sample_t audio_l,
  output zx_audio_pkg::sample_t audio_r
);

  import zx_bus_pkg::*;
  import zx_audio_pkg::*;

  io_cycle_t  io;
  int_src_t   int_mask;
  audio_in_t  aud;
  logic       intack_stb;
  logic [7:0] vector;
  logic       vec_src_valid;

  // bus side
  z80_bus_sync u_bus_sync (
    .clk_28mhz  (clk_28mhz),
    .rst        (rst),
    .iorq_n     (iorq_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .m1_n       (m1_n),
    .addr       (addr),
    .data       (data),
    .io         (io),
    .intack_stb (intack_stb)
  );

  zx_ports u_ports (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .io            (io),
    .covox_en      (covox_en),
    .tape_in       (tape_in),
    .kbd_data      (kbd_data),
    .vector        (vector),
    .vec_src_valid (vec_src_valid),
    .int_mask      (int_mask),
    .aud           (aud),
    .border        (border),
    .tape_out      (tape_out),
    .cpu_di        (cpu_di)
  );

  int_ctrl #(
    .frame_clks (frame_clks)
  ) u_int_ctrl (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .intack_stb    (intack_stb),
    .ext_int       (ext_int),
    .int_mask      (int_mask),
    .int_n         (int_n),
    .vector        (vector),
    .vec_src_valid (vec_src_valid)
  );

  // sound output
  audio_mixer u_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .aud       (aud),
    .audio_l   (audio_l),
    .audio_r   (audio_r),
    .beep      (beep)
  );

endmodule

// File: zx_ports.sv
`timescale 1ns/1ps
`include "zx_io_consts.svh"

module zx_ports (
  input  logic                    clk_28mhz,
  input  logic                    rst,
  input  zx_bus_pkg::io_cycle_t   io,
  input  logic                    covox_en,
  input  logic                    tape_in,
  input  logic [4:0]              kbd_data,
  input  logic [7:0]              vector,
  input  logic                    vec_src_valid,
  output zx_bus_pkg::int_src_t    int_mask,
  output zx_audio_pkg::audio_in_t aud,
  output logic [2:0]              border,
  output logic                    tape_out,
  output logic [7:0]              cpu_di
);

  import zx_bus_pkg::*;

  localparam logic [7:0] FE_LO = `ZX_PORT_FE_LO;

  fe_port_u   fe_q;
  logic [7:0] covox_q;
  logic       sel_fe;
  logic       sel_covox;
  logic       sel_mask;

  // port decode on the synchronised address
  assign sel_fe    = io.addr[0] == FE_LO[0];
  assign sel_covox = io.addr[7:0] == `ZX_PORT_COVOX;
  assign sel_mask  = io.addr == {`ZX_PORT_INTMASK_HI, `ZX_PORT_INTMASK_LO};

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_q.raw <= 8'h00;
      covox_q  <= 8'h00;
      // frame interrupt only
      int_mask <= '{line: 1'b0, frame: 1'b1};
    end else if (io.wr_stb) begin
      if (sel_fe) begin
        fe_q.raw <= io.data;
      end
      if (sel_covox && covox_en) begin
        covox_q <= io.data;
      end
      if (sel_mask) begin
        int_mask <= io.data[1:0];
      end
    end
  end

  assign border   = fe_q.f.border;
  assign tape_out = fe_q.f.tape_out;

  assign aud = '{speaker: fe_q.f.speaker, tape_in: tape_in, covox: covox_q};

  // read data mux with the vector first during acknowledge
  always_comb begin
    if (vec_src_valid) begin
      cpu_di = vector;
    end else if (io.rd_act && sel_fe) begin
      cpu_di = {1'b1, tape_in, 1'b1, kbd_data};
    end else begin
      cpu_di = 8'hFF;
    end
  end

endmodule
